// ==== all.f ====
src/memtest_pkg.sv
src/serial_pkg.sv
src/report_if.sv
src/init_ram.sv
src/rom_checker.sv
src/error_reporter.sv
src/uart_tx.sv
src/bram_test_top.sv
tb/bram_test_properties.sv
tb/bram_test_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bram_test_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= Finished with errors

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/bram_test_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram_test_tb
    import memtest_pkg::*;
    import serial_pkg::*;
();

    localparam int addr_width   = 6;
    localparam int data_width   = 16;
    localparam int clks_per_bit = 4;
    localparam int max_cycles   = 40000;
    localparam logic [addr_width-1:0] last_addr = '1;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  wr_en;
    logic [addr_width-1:0] wr_addr;
    logic [data_width-1:0] wr_data;
    logic                  tx;

    byte_t                 rx_q [$];  // decoded bytes, oldest first.
    int unsigned           reset_count = 0;
    int unsigned           cycle_count = 0;
    int unsigned           check_count = 0;
    int unsigned           error_count = 0;
    logic [addr_width-1:0] corrupt_addr;

    bram_test_top #(
        .addr_width  (addr_width),
        .data_width  (data_width),
        .clks_per_bit(clks_per_bit)
    ) i_bram_test_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .tx     (tx)
    );

    always #20 clk = ~clk;

    always @(negedge rst_n) reset_count++;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("timeout, no result after %0d cycles", max_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // ========================================
    // serial decoder
    // ========================================
    always begin : serial_decoder
        byte_t       data;
        int unsigned resets_at_start;
        wait (rst_n === 1'b1);
        @(negedge tx);
        resets_at_start = reset_count;
        repeat (clks_per_bit / 2) @(negedge clk);  // middle of start bit.
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            data[i] = tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        // a reset inside the byte throws it away.
        if (reset_count == resets_at_start) begin
            assert (tx === 1'b1) else begin
                error_count++;
                $display("stop bit on tx was low, byte 0x%h dropped", data);
            end
            if (tx === 1'b1) rx_q.push_back(data);
        end
    end

    // ========================================
    // helpers
    // ========================================
    task automatic write_word(input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    function automatic logic [data_width-1:0] wrong_value(input logic [addr_width-1:0] addr);
        logic [data_width-1:0] v;
        v = data_width'($urandom);
        if (v == data_width'(addr)) v = ~v;
        return v;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic pop_byte(output byte_t b);
        while (rx_q.size() == 0) @(posedge clk);
        b = rx_q.pop_front();
    endtask

    task automatic flush_rx();
        rx_q.delete();
    endtask

    // one sweep byte, or a whole error frame.
    task automatic next_event(output logic is_error, output logic [15:0] f_addr,
                              output logic [15:0] f_exp, output logic [15:0] f_act);
        byte_t b;
        byte_t fb [error_frame_len-1];
        pop_byte(b);
        is_error = (b == code_error);
        f_addr   = '0;
        f_exp    = '0;
        f_act    = '0;
        if (is_error) begin
            for (int i = 0; i < error_frame_len - 1; i++) pop_byte(fb[i]);
            f_addr = {fb[0], fb[1]};
            f_exp  = {fb[2], fb[3]};
            f_act  = {fb[4], fb[5]};
        end else begin
            check_value("tx byte", 16'(code_loop), 16'(b));
        end
    endtask

    task automatic expect_loop();
        logic        is_error;
        logic [15:0] f_addr;
        logic [15:0] f_exp;
        logic [15:0] f_act;
        next_event(is_error, f_addr, f_exp, f_act);
        check_count++;
        assert (!is_error) else begin
            error_count++;
            $display("error frame for address 0x%h where only a sweep byte was due", f_addr);
        end
    endtask

    task automatic expect_frame(input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] value);
        logic        is_error;
        logic [15:0] f_addr;
        logic [15:0] f_exp;
        logic [15:0] f_act;
        next_event(is_error, f_addr, f_exp, f_act);
        check_count++;
        assert (is_error) else begin
            error_count++;
            $display("sweep byte arrived where the frame for address 0x%h was due", addr);
        end
        if (is_error) begin
            check_value("frame address", 16'(addr), f_addr);
            check_value("frame expected", 16'(addr), f_exp);  // word holds its address.
            check_value("frame actual", 16'(value), f_act);
        end
    endtask

    // drop whatever is left of the sweep running during a write.
    task automatic skip_partial_sweep();
        logic        is_error;
        logic [15:0] f_addr;
        logic [15:0] f_exp;
        logic [15:0] f_act;
        flush_rx();
        is_error = 1'b1;
        while (is_error) next_event(is_error, f_addr, f_exp, f_act);
    endtask

    // ========================================
    // tests
    // ========================================
    task automatic clean_memory();
        repeat (4) expect_loop();
    endtask

    task automatic single_corruption();
        logic [data_width-1:0] value;
        corrupt_addr = addr_width'($urandom % (2 ** addr_width - 1));  // below last.
        value        = wrong_value(corrupt_addr);
        write_word(corrupt_addr, value);
        skip_partial_sweep();
        expect_frame(corrupt_addr, value);
        expect_loop();
    endtask

    task automatic restore_word();
        write_word(corrupt_addr, data_width'(corrupt_addr));
        skip_partial_sweep();
        repeat (3) expect_loop();
    endtask

    task automatic multi_corruption();
        logic [addr_width-1:0] addrs [3];
        logic [data_width-1:0] vals [3];
        logic [addr_width-1:0] a_tmp;
        logic [data_width-1:0] v_tmp;
        addrs[0] = addr_width'($urandom);
        do addrs[1] = addr_width'($urandom); while (addrs[1] == addrs[0]);
        do addrs[2] = addr_width'($urandom);
        while (addrs[2] == addrs[0] || addrs[2] == addrs[1]);
        for (int i = 0; i < 3; i++) vals[i] = wrong_value(addrs[i]);
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2 - i; j++) begin
                if (addrs[j] > addrs[j+1]) begin
                    a_tmp      = addrs[j];
                    addrs[j]   = addrs[j+1];
                    addrs[j+1] = a_tmp;
                    v_tmp      = vals[j];
                    vals[j]    = vals[j+1];
                    vals[j+1]  = v_tmp;
                end
            end
        end
        for (int i = 0; i < 3; i++) write_word(addrs[i], vals[i]);
        skip_partial_sweep();
        for (int i = 0; i < 3; i++) expect_frame(addrs[i], vals[i]);  // ascending.
        expect_loop();
        for (int i = 0; i < 3; i++) write_word(addrs[i], data_width'(addrs[i]));
        skip_partial_sweep();
        expect_loop();
    endtask

    task automatic last_address();
        logic [data_width-1:0] value;
        value = wrong_value(last_addr);
        write_word(last_addr, value);
        skip_partial_sweep();
        expect_frame(last_addr, value);  // frame before the sweep byte.
        expect_loop();
        write_word(last_addr, data_width'(last_addr));
        skip_partial_sweep();
    endtask

    task automatic reset_mid_frame();
        logic [addr_width-1:0] addr;
        byte_t                 b;
        addr = addr_width'($urandom);
        write_word(addr, wrong_value(addr));
        flush_rx();
        b = 8'h00;
        while (b != code_error) pop_byte(b);
        repeat (clks_per_bit * 4) @(posedge clk);  // inside the address byte.
        rst_n <= 1'b0;
        @(negedge clk);
        check_value("tx", 16'h0001, 16'(tx));
        write_word(addr, data_width'(addr));  // ram has no reset.
        @(posedge clk);
        rst_n <= 1'b1;
        flush_rx();
        repeat (3) expect_loop();
    endtask

    initial begin
        void'($urandom(78));
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        clean_memory();
        single_corruption();
        restore_word();
        multi_corruption();
        last_address();
        reset_mid_frame();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/bram_test_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram_test_properties #(
    parameter int addr_width = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  busy,
    input  logic [addr_width-1:0] rd_addr,
    input  logic                  err_pulse,
    input  logic                  tx_busy,
    input  logic                  tx
);

    // checker holds its address while the reporter is sending.
    addr_holds: assert property (@(posedge clk) disable iff (!rst_n)
        busy |=> $stable(rd_addr))
        else $error("rd_addr moved while busy was high");

    err_single: assert property (@(posedge clk) disable iff (!rst_n)
        err_pulse |=> !err_pulse)
        else $error("err_pulse stayed high for more than one cycle");

    line_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx)
        else $error("tx was low while tx_busy was low");

endmodule

// checker side, serial inputs tied to idle.
bind rom_checker bram_test_properties #(.addr_width(addr_width)) i_chk_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (rpt.busy),
    .rd_addr  (rd_addr),
    .err_pulse(rpt.err_pulse),
    .tx_busy  (1'b0),
    .tx       (1'b1)
);

// transmitter side, checker inputs tied off.
bind uart_tx bram_test_properties #(.addr_width(1)) i_tx_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (1'b0),
    .rd_addr  (1'b0),
    .err_pulse(1'b0),
    .tx_busy  (tx_busy),
    .tx       (tx)
);

`default_nettype wire

// ==== src/bram_test_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram_test_top
    import serial_pkg::*;
#(
    parameter int addr_width   = 10,
    parameter int data_width   = 16,
    parameter int clks_per_bit = 25
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data,
    output logic                  tx
);

    logic [addr_width-1:0] rd_addr;
    logic [data_width-1:0] rd_data;
    logic                  tx_start;
    byte_t                 tx_byte;
    logic                  tx_busy;

    report_if #(
        .addr_width(addr_width),
        .data_width(data_width)
    ) rpt_if ();

    init_ram #(
        .addr_width(addr_width),
        .data_width(data_width)
    ) i_init_ram (
        .clk    (clk),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    rom_checker #(
        .addr_width(addr_width),
        .data_width(data_width)
    ) i_rom_checker (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .rpt    (rpt_if.chkr)
    );

    error_reporter #(
        .addr_width(addr_width),
        .data_width(data_width)
    ) i_error_reporter (
        .clk     (clk),
        .rst_n   (rst_n),
        .rpt     (rpt_if.reporter),
        .tx_start(tx_start),
        .tx_byte (tx_byte),
        .tx_busy (tx_busy)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_start(tx_start),
        .tx_byte (tx_byte),
        .tx_busy (tx_busy),
        .tx      (tx)
    );

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx
    import serial_pkg::*;
#(
    parameter int clks_per_bit = 25
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tx_start,
    input  byte_t tx_byte,
    output logic  tx_busy,
    output logic  tx
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int idx_w = $clog2(bits_per_frame);

    logic [bits_per_frame-1:0] shift_q;  // lsb is on the line.
    logic [cnt_w-1:0]          clk_cnt;
    logic [idx_w-1:0]          bit_idx;
    logic                      bit_done;

    assign bit_done = (clk_cnt == cnt_w'(clks_per_bit - 1));
    assign tx       = shift_q[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '1;  // line idles high.
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            if (tx_start) begin
                shift_q <= {1'b1, tx_byte, 1'b0};  // stop, data, start.
                tx_busy <= 1'b1;
            end
        end else if (bit_done) begin
            clk_cnt <= '0;
            shift_q <= {1'b1, shift_q[bits_per_frame-1:1]};  // refill with idle.
            if (bit_idx == idx_w'(bits_per_frame - 1)) begin
                tx_busy <= 1'b0;  // end of stop bit.
                bit_idx <= '0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/error_reporter.sv ====
`timescale 1ns/10ps
`default_nettype none

module error_reporter
    import memtest_pkg::*;
    import serial_pkg::*;
#(
    parameter int addr_width = 10,
    parameter int data_width = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    report_if.reporter rpt,
    output logic       tx_start,
    output byte_t      tx_byte,
    input  logic       tx_busy
);

    localparam int idx_w = $clog2(error_frame_len);

    logic [addr_width-1:0] addr_q;
    logic [data_width-1:0] exp_q;
    logic [data_width-1:0] act_q;
    logic [15:0]           addr_f;
    logic [15:0]           exp_f;
    logic [15:0]           act_f;
    logic                  err_pend;
    logic                  sweep_pend;
    logic [idx_w-1:0]      idx;
    logic                  can_send;
    logic                  idle;
    byte_t                 frame_byte;

    // fields go out as 16-bit values.
    assign addr_f = 16'(addr_q);
    assign exp_f  = 16'(exp_q);
    assign act_f  = 16'(act_q);

    assign can_send = !tx_start && !tx_busy && (err_pend || sweep_pend);
    assign idle     = !tx_start && !tx_busy && !err_pend && !sweep_pend;

    always_comb begin
        case (idx)
            0:       frame_byte = code_error;
            1:       frame_byte = addr_f[15:8];
            2:       frame_byte = addr_f[7:0];
            3:       frame_byte = exp_f[15:8];
            4:       frame_byte = exp_f[7:0];
            5:       frame_byte = act_f[15:8];
            default: frame_byte = act_f[7:0];
        endcase
    end

    // ========================================
    // byte sequencing
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_pend   <= 1'b0;
            sweep_pend <= 1'b0;
            idx        <= '0;
            tx_start   <= 1'b0;
            rpt.busy   <= 1'b0;
        end else begin
            tx_start <= can_send;
            if (can_send) begin
                if (err_pend) begin  // error frame goes before code_loop.
                    if (idx == idx_w'(error_frame_len - 1)) begin
                        idx      <= '0;
                        err_pend <= 1'b0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end else begin
                    sweep_pend <= 1'b0;
                end
            end
            if (rpt.err_pulse) err_pend <= 1'b1;
            if (rpt.sweep_pulse) sweep_pend <= 1'b1;
            if (rpt.err_pulse || rpt.sweep_pulse) begin
                rpt.busy <= 1'b1;
            end else if (idle) begin
                rpt.busy <= 1'b0;  // last byte has left the line.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rpt.err_pulse) begin
            addr_q <= rpt.err_addr;
            exp_q  <= rpt.err_expected;
            act_q  <= rpt.err_actual;
        end
        if (can_send) begin
            tx_byte <= err_pend ? frame_byte : code_loop;
        end
    end

endmodule

`default_nettype wire

// ==== src/rom_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module rom_checker
    import memtest_pkg::*;
#(
    parameter int addr_width = 10,
    parameter int data_width = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [addr_width-1:0] rd_addr,
    input  logic [data_width-1:0] rd_data,
    report_if.chkr                rpt
);

    localparam logic [addr_width-1:0] last_addr = '1;

    chk_state_t            state;
    chk_state_t            state_nxt;
    logic                  issue;
    logic                  vld_q;     // word on rd_data belongs to addr_q.
    logic [addr_width-1:0] addr_q;
    logic [data_width-1:0] expected;
    logic                  mismatch;

    assign expected = data_width'(addr_q);  // zero-extended address.
    assign mismatch = vld_q && (rd_data != expected);
    assign issue    = !rpt.busy && (state != halted_report);

    // ========================================
    // state machine
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            reading: begin
                if (mismatch) state_nxt = halted_report;
                else if (rpt.busy) state_nxt = stalled;
            end
            stalled: begin
                if (mismatch) state_nxt = halted_report;
                else if (!rpt.busy) state_nxt = reading;
            end
            halted_report: begin
                if (rpt.busy) state_nxt = stalled;  // report has started.
            end
            default: state_nxt = reading;
        endcase
    end

    // ========================================
    // address sweep and compare
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= reading;
            rd_addr         <= '0;
            vld_q           <= 1'b0;
            rpt.err_pulse   <= 1'b0;
            rpt.sweep_pulse <= 1'b0;
        end else begin
            state           <= state_nxt;
            vld_q           <= issue && !mismatch;  // drop the read in flight.
            rpt.err_pulse   <= mismatch;
            rpt.sweep_pulse <= vld_q && (addr_q == last_addr);
            if (mismatch) begin
                rd_addr <= addr_q + 1'b1;  // resume after the bad word.
            end else if (issue) begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= rd_addr;
        if (mismatch) begin
            rpt.err_addr     <= addr_q;
            rpt.err_expected <= expected;
            rpt.err_actual   <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/init_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module init_ram #(
    parameter int addr_width = 10,
    parameter int data_width = 16
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] rd_addr,
    output logic [data_width-1:0] rd_data,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data
);

    localparam int depth = 2 ** addr_width;

    logic [data_width-1:0] mem [0:depth-1];

    // every word starts out holding its own address.
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = data_width'(i);
        end
    end

    // read and write share the clock, so a colliding read sees the old word.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // registered read.
    end

endmodule

`default_nettype wire

// ==== src/report_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface report_if #(
    parameter int addr_width = 10,
    parameter int data_width = 16
);

    logic                  err_pulse;     // one cycle per mismatch.
    logic [addr_width-1:0] err_addr;
    logic [data_width-1:0] err_expected;
    logic [data_width-1:0] err_actual;
    logic                  sweep_pulse;   // one cycle per full sweep.
    logic                  busy;          // reporter still sending.

    modport chkr (
        output err_pulse,
        output err_addr,
        output err_expected,
        output err_actual,
        output sweep_pulse,
        input  busy
    );

    modport reporter (
        input  err_pulse,
        input  err_addr,
        input  err_expected,
        input  err_actual,
        input  sweep_pulse,
        output busy
    );

endinterface

`default_nettype wire

// ==== src/serial_pkg.sv ====
`default_nettype none

package serial_pkg;

    typedef logic [7:0] byte_t;

    // start bit, 8 data bits lsb first, stop bit.
    localparam int bits_per_frame = 10;

endpackage

`default_nettype wire

// ==== src/memtest_pkg.sv ====
`default_nettype none

package memtest_pkg;

    // ========================================
    // checker state
    // ========================================
    typedef enum logic [1:0] {
        reading       = 2'd0,  // one address per cycle.
        stalled       = 2'd1,  // waiting on the reporter.
        halted_report = 2'd2   // mismatch seen, busy not up yet.
    } chk_state_t;

    // ========================================
    // report byte codes
    // ========================================
    localparam logic [7:0] code_error = 8'h45;  // 'E', leads an error frame.
    localparam logic [7:0] code_loop  = 8'h4C;  // 'L', one per sweep.

    // code, then address, expected and actual as 16-bit big endian.
    localparam int error_frame_len = 7;

endpackage

`default_nettype wire
